/* dv/flight_mode_tb.sv */
// Flight mode supervisor testbench: directed tests of start-up, decode, averaging and mode changes
`timescale 1ns/10ps
`default_nettype none

module flight_mode_tb;
	import drone_values_pkg::*;
	import flight_modes_pkg::*;

	localparam int unsigned INIT_CYCLES    = 20;
	localparam int unsigned TIMEOUT_CYCLES = 3000;	// Well above the length of all tests
	localparam logic [31:0] LFSR_SEED      = 32'h7b9c473b;

	logic           us_clk = 1'b0;
	logic           machxo3_switch_reset_n;
	logic           soft_reset_n;
	logic [7:0]     imu_calib_status;
	logic [7:0]     swa_swb_val;
	logic [7:0]     throttle;
	motor_rates_t   rates;
	logic           resetn;
	flight_mode_t   mode;
	rec_sel_t       rec_data_sel;
	imu_sel_t       imu_data_sel;
	logic [7:0]     avg_rate;
	logic [15:0]    debug_leds;

	logic [31:0]    lfsr;
	int             cycle_count  = 0;
	int             test_errors  = 0;
	int             total_errors = 0;
	int             tests_run    = 0;
	int             tests_failed = 0;

	flight_mode_top #(
		.INIT_CYCLES(INIT_CYCLES)
	) i_dut (
		.us_clk                 (us_clk),
		.machxo3_switch_reset_n (machxo3_switch_reset_n),
		.soft_reset_n           (soft_reset_n),
		.imu_calib_status       (imu_calib_status),
		.swa_swb_val            (swa_swb_val),
		.throttle               (throttle),
		.rates                  (rates),
		.resetn                 (resetn),
		.mode                   (mode),
		.rec_data_sel           (rec_data_sel),
		.imu_data_sel           (imu_data_sel),
		.avg_rate               (avg_rate),
		.debug_leds             (debug_leds)
	);

	always #2 us_clk = ~us_clk;	// 4 ns period

	// Hard stop if a test never ends
	always @(posedge us_clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [7:0] random_byte();
		logic [7:0] b;
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);	// One step per bit
			b    = {b[6:0], lfsr[0]};
		end
		return b;
	endfunction

	// Expected switch code from the channel ranges
	function automatic logic [7:0] expected_position(input logic [7:0] val);
		if (val >= SW_USER_IMU_MIN && val <= SW_USER_IMU_MAX)
			return SW_USER_IMU;
		if (val >= SW_TAKE_OFF_IMU_MIN && val <= SW_TAKE_OFF_IMU_MAX)
			return SW_TAKE_OFF_IMU;
		if (val >= SW_USER_NO_IMU_MIN && val <= SW_USER_NO_IMU_MAX)
			return SW_USER_NO_IMU;
		if (val >= SW_TAKE_OFF_NO_IMU_MIN && val <= SW_TAKE_OFF_NO_IMU_MAX)
			return SW_TAKE_OFF_NO_IMU;
		return SW_OFF;	// Off range and anything unmatched
	endfunction

	// Route table per mode
	function automatic rec_sel_t expected_rec_sel(input flight_mode_t m);
		case (m)
			MODE_USER_IMU, MODE_USER_NO_IMU: return REC_SEL_PASS_THROUGH;
			MODE_TAKE_OFF:                   return REC_SEL_AUTO_TAKE_OFF;
			MODE_HOVER:                      return REC_SEL_HOVER;
			MODE_AUTO_LAND:                  return REC_SEL_AUTO_LAND;
			default:                         return REC_SEL_OFF;
		endcase
	endfunction

	function automatic imu_sel_t expected_imu_sel(input flight_mode_t m);
		return (m == MODE_USER_NO_IMU) ? IMU_SEL_DISABLE : IMU_SEL_PASS_THROUGH;
	endfunction

	task automatic step_clock();
		@(posedge us_clk);
		#1;	// Drive and sample clear of the edge
	endtask

	task automatic report_mismatch(input string sig, input logic [31:0] got,
			input logic [31:0] exp);
		$display("ERROR %s: got %h, expected %h at %0t", sig, got, exp, $time);
		test_errors = test_errors + 1;
	endtask

	task automatic close_test(input string name);
		$display("%s: %s (%0d errors)", name,
			(test_errors == 0) ? "PASS" : "FAIL", test_errors);
		tests_run    = tests_run + 1;
		total_errors = total_errors + test_errors;
		if (test_errors != 0)
			tests_failed = tests_failed + 1;
		test_errors = 0;
	endtask

	task automatic expect_mode(input flight_mode_t exp);
		if (mode !== exp)
			report_mismatch("mode", mode, exp);
		if (rec_data_sel !== expected_rec_sel(exp))
			report_mismatch("rec_data_sel", rec_data_sel, expected_rec_sel(exp));
		if (imu_data_sel !== expected_imu_sel(exp))
			report_mismatch("imu_data_sel", imu_data_sel, expected_imu_sel(exp));
	endtask

	// Channel and rates both reach the mode after two edges
	task automatic mode_step(input logic [7:0] chan, input logic [7:0] thr,
			input logic [7:0] rate, input flight_mode_t exp);
		swa_swb_val = chan;
		throttle    = thr;
		rates       = {rate, rate, rate, rate};
		step_clock();
		step_clock();
		expect_mode(exp);
	endtask

	task automatic startup_sequence();
		int n;
		if (debug_leds !== 16'h0000)
			report_mismatch("debug_leds", debug_leds, 16'h0000);
		if (avg_rate !== 8'd0)
			report_mismatch("avg_rate", avg_rate, 8'd0);
		expect_mode(MODE_STASIS);
		// IMU not calibrated yet, so no readiness even after the count expires
		for (n = 0; n < 60; n++) begin
			step_clock();
			if (debug_leds[15] !== 1'b0)
				report_mismatch("debug_leds[15]", debug_leds[15], 1'b0);
		end
		imu_calib_status = CALIB_DONE_VAL;
		n = 0;
		while (debug_leds[15] !== 1'b1 && n < INIT_CYCLES + 2) begin
			step_clock();
			n++;
		end
		if (debug_leds[15] !== 1'b1) begin
			$display("ERROR readiness did not rise within %0d cycles of calibration", n);
			test_errors = test_errors + 1;
		end
		expect_mode(MODE_STASIS);
		close_test("startup");
	endtask

	task automatic switch_decode_sweep();
		logic [7:0] lo [5];
		logic [7:0] hi [5];
		logic [7:0] vals [$];
		lo = '{SW_OFF_MIN, SW_USER_IMU_MIN, SW_TAKE_OFF_IMU_MIN,
		       SW_USER_NO_IMU_MIN, SW_TAKE_OFF_NO_IMU_MIN};
		hi = '{SW_OFF_MAX, SW_USER_IMU_MAX, SW_TAKE_OFF_IMU_MAX,
		       SW_USER_NO_IMU_MAX, SW_TAKE_OFF_NO_IMU_MAX};
		vals.push_back(8'd0);
		vals.push_back(8'd255);
		for (int i = 0; i < 5; i++) begin
			vals.push_back(lo[i] - 8'd1);	// Just outside below
			vals.push_back(lo[i]);
			vals.push_back(8'((16'(lo[i]) + 16'(hi[i])) >> 1));
			vals.push_back(hi[i]);
			vals.push_back(hi[i] + 8'd1);	// Just outside above
		end
		foreach (vals[i]) begin
			swa_swb_val = vals[i];
			step_clock();
			step_clock();
			if (debug_leds[7:0] !== expected_position(vals[i]))
				report_mismatch("debug_leds[7:0]", debug_leds[7:0],
					expected_position(vals[i]));
		end
		mode_step(8'd123, 8'd0, 8'd0, MODE_STASIS);	// Park switch off
		close_test("switch_decode");
	endtask

	task automatic rate_average_check();
		logic [7:0] r [4];
		int sum;
		for (int set = 0; set < 40; set++) begin
			for (int k = 0; k < 4; k++) begin
				r[k] = random_byte();
				if (set % 4 == 0)
					r[k] = 8'hF0 | {4'h0, r[k][3:0]};	// Near full scale so the sum carries
			end
			sum   = int'(r[0]) + int'(r[1]) + int'(r[2]) + int'(r[3]);
			rates = {r[0], r[1], r[2], r[3]};
			step_clock();
			if (avg_rate !== 8'(sum / 4))
				report_mismatch("avg_rate", avg_rate, 8'(sum / 4));
		end
		rates = '0;
		step_clock();
		step_clock();
		step_clock();	// Let the forced landing settle back to stasis
		expect_mode(MODE_STASIS);
		close_test("rate_average");
	endtask

	task automatic mode_walk();
		mode_step(8'd225, 8'd0, 8'd0, MODE_USER_IMU);
		mode_step(8'd173, 8'd0, 8'd0, MODE_USER_NO_IMU);
		mode_step(8'd73, 8'd0, 8'd0, MODE_TAKE_OFF);	// On the ground
		mode_step(8'd73, 8'd0, 8'd130, MODE_HOVER);	// Climb done
		mode_step(8'd173, 8'd50, 8'd130, MODE_HOVER);	// Stick too low to hand back
		mode_step(8'd173, 8'd200, 8'd130, MODE_USER_NO_IMU);
		close_test("mode_walk");
	endtask

	task automatic auto_land_sequence();
		mode_step(8'd123, 8'd0, 8'd130, MODE_AUTO_LAND);
		mode_step(8'd123, 8'd0, 8'd50, MODE_AUTO_LAND);	// Still airborne
		mode_step(8'd123, 8'd0, 8'd8, MODE_STASIS);
		close_test("auto_land");
	endtask

	task automatic soft_reset_sequence();
		int n;
		mode_step(8'd225, 8'd0, 8'd0, MODE_USER_IMU);
		mode_step(8'd225, 8'd0, 8'd100, MODE_USER_IMU);
		soft_reset_n = 1'b0;
		#1;
		if (resetn !== 1'b0)
			report_mismatch("resetn", resetn, 1'b0);
		if (debug_leds[15] !== 1'b0)
			report_mismatch("debug_leds[15]", debug_leds[15], 1'b0);
		step_clock();
		soft_reset_n = 1'b1;
		step_clock();
		expect_mode(MODE_AUTO_LAND);	// Airborne when readiness dropped
		n = 1;
		while (debug_leds[15] !== 1'b1 && n < INIT_CYCLES + 2) begin
			step_clock();
			n++;
		end
		if (debug_leds[15] !== 1'b1 || n < INIT_CYCLES) begin
			$display("Readiness took %0d cycles after soft reset, expected %0d to %0d",
				n, INIT_CYCLES, INIT_CYCLES + 2);
			test_errors = test_errors + 1;
		end
		close_test("soft_reset");
	endtask

	initial begin
		machxo3_switch_reset_n = 1'b0;
		soft_reset_n           = 1'b1;
		imu_calib_status       = 8'h00;	// IMU still calibrating
		swa_swb_val            = 8'd123;	// Switch off
		throttle               = 8'd0;
		rates                  = '0;
		lfsr                   = LFSR_SEED;
		repeat (4) @(posedge us_clk);
		#1;
		machxo3_switch_reset_n = 1'b1;

		startup_sequence();
		switch_decode_sweep();
		rate_average_check();
		mode_walk();
		auto_land_sequence();
		soft_reset_sequence();

		$display("Tests run %0d, tests failing %0d, check errors %0d",
			tests_run, tests_failed, total_errors);
		if (total_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the flight mode supervisor testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

TOP=flight_mode_tb
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f verilog.f \
	--top-module "${TOP}" \
	--Mdir "${OBJ_DIR}" \
	-o "${TOP}"
status=$?
if [ ${status} -ne 0 ]; then
	echo "Verilator build failed with status ${status}"
	exit 1
fi

"./${OBJ_DIR}/${TOP}" > "${LOG}" 2>&1
status=$?
cat "${LOG}"
if [ ${status} -ne 0 ]; then
	echo "Simulation run exited with status ${status}"
	exit 1
fi

if grep -q "Simulation completed successfully" "${LOG}"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

/* verilog.f */
verilog/drone_values_pkg.sv
verilog/flight_modes_pkg.sv
verilog/init_timer.sv
verilog/switch_decoder.sv
verilog/motor_rate_average.sv
verilog/flight_mode_fsm.sv
verilog/flight_mode_top.sv
dv/flight_mode_tb.sv

/* verilog/drone_values_pkg.sv */
// Drone value constants: bus widths, switch channel ranges, motor thresholds, motor rate struct
`default_nettype none

package drone_values_pkg;

	// Bus widths
	localparam int REC_VAL_WIDTH    = 8;	// One receiver channel value
	localparam int MOTOR_RATE_WIDTH = 8;	// One motor rate

	// IMU calibration status once calibration is finished
	localparam logic [REC_VAL_WIDTH-1:0] CALIB_DONE_VAL = 8'hFF;

	// Motor thresholds
	localparam logic [MOTOR_RATE_WIDTH-1:0] MOTOR_VAL_MIN      = 8'd10;	// On the ground at or below
	localparam logic [MOTOR_RATE_WIDTH-1:0] HOVER_THROTTLE_VAL = 8'd120;	// Hovering at or above

	// SWA/SWB channel ranges, both ends inclusive
	localparam logic [REC_VAL_WIDTH-1:0] SW_OFF_MIN              = 8'd118;
	localparam logic [REC_VAL_WIDTH-1:0] SW_OFF_MAX              = 8'd128;
	localparam logic [REC_VAL_WIDTH-1:0] SW_USER_IMU_MIN         = 8'd220;
	localparam logic [REC_VAL_WIDTH-1:0] SW_USER_IMU_MAX         = 8'd230;
	localparam logic [REC_VAL_WIDTH-1:0] SW_TAKE_OFF_IMU_MIN     = 8'd18;
	localparam logic [REC_VAL_WIDTH-1:0] SW_TAKE_OFF_IMU_MAX     = 8'd28;
	localparam logic [REC_VAL_WIDTH-1:0] SW_USER_NO_IMU_MIN      = 8'd168;
	localparam logic [REC_VAL_WIDTH-1:0] SW_USER_NO_IMU_MAX      = 8'd178;
	localparam logic [REC_VAL_WIDTH-1:0] SW_TAKE_OFF_NO_IMU_MIN  = 8'd68;
	localparam logic [REC_VAL_WIDTH-1:0] SW_TAKE_OFF_NO_IMU_MAX  = 8'd78;

	// Rates of the four motors as reported by the mixer
	typedef struct packed {
		logic [MOTOR_RATE_WIDTH-1:0] motor_1;	// Upper byte
		logic [MOTOR_RATE_WIDTH-1:0] motor_2;
		logic [MOTOR_RATE_WIDTH-1:0] motor_3;
		logic [MOTOR_RATE_WIDTH-1:0] motor_4;	// Lower byte
	} motor_rates_t;

endpackage

`default_nettype wire

/* verilog/flight_mode_fsm.sv */
// Flight mode FSM: picks the flight mode and routes receiver and IMU data accordingly
`timescale 1ns/10ps
`default_nettype none

module flight_mode_fsm (
	input  logic                                        us_clk,
	input  logic                                        machxo3_switch_reset_n,
	input  logic                                        sys_rdy,
	input  flight_modes_pkg::sw_pos_t                   position,
	input  logic [drone_values_pkg::REC_VAL_WIDTH-1:0]    throttle,	// Pilot throttle stick
	input  logic [drone_values_pkg::MOTOR_RATE_WIDTH-1:0] avg_rate,	// Mean motor rate
	output flight_modes_pkg::flight_mode_t              mode,
	output flight_modes_pkg::rec_sel_t                  rec_data_sel,
	output flight_modes_pkg::imu_sel_t                  imu_data_sel
);
	import drone_values_pkg::*;
	import flight_modes_pkg::*;

	flight_mode_t mode_next;
	flight_mode_t safe_mode;	// Where to go when control is taken away
	flight_mode_t user_mode;	// User mode matching the current position
	logic         user_pos;		// Switch is in a pilot position
	logic         on_ground;
	logic         pilot_ahead;	// Throttle has caught up with the motors

	assign on_ground   = (avg_rate <= MOTOR_VAL_MIN);
	assign pilot_ahead = (throttle >= avg_rate);
	assign user_pos    = (position == SW_USER_IMU) || (position == SW_USER_NO_IMU);
	assign user_mode   = (position == SW_USER_IMU) ? MODE_USER_IMU : MODE_USER_NO_IMU;

	// Land if airborne, else sit still
	// Also covers AUTO_LAND holding until the motors are down
	assign safe_mode = on_ground ? MODE_STASIS : MODE_AUTO_LAND;

	always_comb begin
		mode_next = mode;	// Hold unless a rule fires
		if (!sys_rdy || position == SW_OFF) begin
			mode_next = safe_mode;
		end else begin
			case (mode)
				MODE_STASIS: begin
					// Pilot must start with throttle down
					if (user_pos && throttle <= MOTOR_VAL_MIN)
						mode_next = user_mode;
				end
				MODE_USER_IMU: begin
					if (position == SW_USER_NO_IMU)
						mode_next = MODE_USER_NO_IMU;
					else if (position == SW_TAKE_OFF_IMU)
						mode_next = on_ground ? MODE_TAKE_OFF : MODE_HOVER;
				end
				MODE_USER_NO_IMU: begin
					if (position == SW_USER_IMU)
						mode_next = MODE_USER_IMU;
					else if (position == SW_TAKE_OFF_NO_IMU)
						mode_next = on_ground ? MODE_TAKE_OFF : MODE_HOVER;
				end
				MODE_TAKE_OFF: begin
					if (user_pos)
						mode_next = pilot_ahead ? user_mode : MODE_HOVER;
					else if (avg_rate >= HOVER_THROTTLE_VAL)
						mode_next = MODE_HOVER;	// Climb finished
				end
				MODE_HOVER: begin
					// Hand back only once the stick can hold altitude
					if (user_pos && throttle >= HOVER_THROTTLE_VAL)
						mode_next = user_mode;
				end
				MODE_AUTO_LAND: begin
					if (on_ground)
						mode_next = MODE_STASIS;
					else if (user_pos && pilot_ahead)
						mode_next = user_mode;	// Pilot takes over mid descent
				end
				default: mode_next = safe_mode;	// Illegal code, recover
			endcase
		end
	end

	always_ff @(posedge us_clk or negedge machxo3_switch_reset_n) begin
		if (!machxo3_switch_reset_n)
			mode <= MODE_STASIS;
		else
			mode <= mode_next;
	end

	// Bus selects follow the mode only
	always_comb begin
		imu_data_sel = IMU_SEL_PASS_THROUGH;
		case (mode)
			MODE_USER_IMU:  rec_data_sel = REC_SEL_PASS_THROUGH;
			MODE_USER_NO_IMU: begin
				rec_data_sel = REC_SEL_PASS_THROUGH;
				imu_data_sel = IMU_SEL_DISABLE;	// Raw sticks, no stabilisation
			end
			MODE_TAKE_OFF:  rec_data_sel = REC_SEL_AUTO_TAKE_OFF;
			MODE_HOVER:     rec_data_sel = REC_SEL_HOVER;
			MODE_AUTO_LAND: rec_data_sel = REC_SEL_AUTO_LAND;
			default:        rec_data_sel = REC_SEL_OFF;	// STASIS and illegal codes
		endcase
	end

	a_mode_legal: assert property (
		@(posedge us_clk) disable iff (!machxo3_switch_reset_n)
		mode inside {MODE_STASIS, MODE_TAKE_OFF, MODE_USER_NO_IMU,
			     MODE_USER_IMU, MODE_AUTO_LAND, MODE_HOVER}
	) else $error("illegal flight mode %0d", mode);

endmodule

`default_nettype wire

/* verilog/flight_mode_top.sv */
// Flight mode supervisor top: start-up timer, switch decoder, rate averager and mode FSM
`timescale 1ns/10ps
`default_nettype none

module flight_mode_top #(
	parameter int unsigned INIT_CYCLES = 1000000	// Start-up delay in clocks
) (
	input  logic                                        us_clk,
	input  logic                                        machxo3_switch_reset_n,
	input  logic                                        soft_reset_n,
	input  logic [drone_values_pkg::REC_VAL_WIDTH-1:0]    imu_calib_status,
	input  logic [drone_values_pkg::REC_VAL_WIDTH-1:0]    swa_swb_val,
	input  logic [drone_values_pkg::REC_VAL_WIDTH-1:0]    throttle,
	input  drone_values_pkg::motor_rates_t              rates,
	output logic                                        resetn,	// To the rest of the SoC
	output flight_modes_pkg::flight_mode_t              mode,
	output flight_modes_pkg::rec_sel_t                  rec_data_sel,
	output flight_modes_pkg::imu_sel_t                  imu_data_sel,
	output logic [drone_values_pkg::MOTOR_RATE_WIDTH-1:0] avg_rate,
	output logic [15:0]                                 debug_leds
);
	import flight_modes_pkg::*;

	logic    sys_rdy;
	sw_pos_t position;

	// LED 15 shows readiness, low byte the switch code
	assign debug_leds = {sys_rdy, 7'b0, position};

	init_timer #(
		.INIT_CYCLES(INIT_CYCLES)
	) i_init_timer (
		.us_clk                 (us_clk),
		.machxo3_switch_reset_n (machxo3_switch_reset_n),
		.soft_reset_n           (soft_reset_n),
		.imu_calib_status       (imu_calib_status),
		.resetn                 (resetn),
		.sys_rdy                (sys_rdy)
	);

	switch_decoder i_switch_decoder (
		.us_clk                 (us_clk),
		.machxo3_switch_reset_n (machxo3_switch_reset_n),
		.sys_rdy                (sys_rdy),
		.swa_swb_val            (swa_swb_val),
		.position               (position)
	);

	motor_rate_average i_motor_rate_average (
		.us_clk                 (us_clk),
		.machxo3_switch_reset_n (machxo3_switch_reset_n),
		.rates                  (rates),
		.avg_rate               (avg_rate)
	);

	flight_mode_fsm i_flight_mode_fsm (
		.us_clk                 (us_clk),
		.machxo3_switch_reset_n (machxo3_switch_reset_n),
		.sys_rdy                (sys_rdy),
		.position               (position),
		.throttle               (throttle),
		.avg_rate               (avg_rate),
		.mode                   (mode),
		.rec_data_sel           (rec_data_sel),
		.imu_data_sel           (imu_data_sel)
	);

endmodule

`default_nettype wire

/* verilog/flight_modes_pkg.sv */
// Flight mode encodings: switch positions, flight modes and data bus select codes
`default_nettype none

package flight_modes_pkg;

	// Decoded SWA/SWB position
	// Upper nibble is SWB, lower nibble is SWA
	typedef enum logic [7:0] {
		SW_OFF             = 8'h00,	// SWA in position 0, SWB ignored
		SW_USER_IMU        = 8'h01,	// SWA 1, SWB 0
		SW_TAKE_OFF_IMU    = 8'h02,	// SWA 2, SWB 0
		SW_USER_NO_IMU     = 8'h11,	// SWA 1, SWB 1
		SW_TAKE_OFF_NO_IMU = 8'h12	// SWA 2, SWB 1
	} sw_pos_t;

	// Flight modes
	// Codes 1 and 6 are unused and illegal
	typedef enum logic [2:0] {
		MODE_STASIS      = 3'd0,	// On the ground, motors idle
		MODE_TAKE_OFF    = 3'd2,	// Automatic climb from the ground
		MODE_USER_NO_IMU = 3'd3,	// Pilot control, no IMU stabilisation
		MODE_USER_IMU    = 3'd4,	// Pilot control with IMU
		MODE_AUTO_LAND   = 3'd5,	// Automatic descent
		MODE_HOVER       = 3'd7	// Hold altitude
	} flight_mode_t;

	// Receiver data route toward the angle controller
	typedef enum logic [2:0] {
		REC_SEL_OFF,		// Receiver data blocked
		REC_SEL_PASS_THROUGH,	// Pilot sticks go straight on
		REC_SEL_AUTO_TAKE_OFF,	// Take-off generator drives the bus
		REC_SEL_HOVER,		// Hover generator drives the bus
		REC_SEL_AUTO_LAND	// Landing generator drives the bus
	} rec_sel_t;

	// IMU data route
	typedef enum logic {
		IMU_SEL_PASS_THROUGH,	// IMU angles feed the controller
		IMU_SEL_DISABLE		// Controller runs open loop
	} imu_sel_t;

endpackage

`default_nettype wire

/* verilog/init_timer.sv */
// Start-up timer: merges the reset sources and holds the system idle until the IMU is calibrated
`timescale 1ns/10ps
`default_nettype none

module init_timer #(
	parameter int unsigned INIT_CYCLES = 1000000	// Minimum start-up delay in clocks
) (
	input  logic                                     us_clk,
	input  logic                                     machxo3_switch_reset_n,	// Board switch
	input  logic                                     soft_reset_n,		// Firmware reset
	input  logic [drone_values_pkg::REC_VAL_WIDTH-1:0] imu_calib_status,
	output logic                                     resetn,
	output logic                                     sys_rdy
);
	import drone_values_pkg::*;

	localparam int CNT_W = $clog2(INIT_CYCLES + 1);

	logic [CNT_W-1:0] count;	// Cycles left before readiness is allowed
	logic             imu_rdy;

	// Either source resets the system
	assign resetn  = machxo3_switch_reset_n & soft_reset_n;
	assign imu_rdy = (imu_calib_status == CALIB_DONE_VAL);

	// Soft reset also restarts the delay
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			count   <= CNT_W'(INIT_CYCLES);
			sys_rdy <= 1'b0;
		end else begin
			if (count != '0)
				count <= count - 1'b1;	// Count down, then park at zero
			if (count == '0 && imu_rdy)
				sys_rdy <= 1'b1;	// Sticky until the next reset
		end
	end

	// Readiness may only follow an expired delay
	a_rdy_after_delay: assert property (
		@(posedge us_clk) disable iff (!resetn)
		sys_rdy |-> (count == '0)
	) else $error("sys_rdy high with start-up count %0d", count);

endmodule

`default_nettype wire

/* verilog/motor_rate_average.sv */
// Motor rate averager: registered mean of the four motor rates
`timescale 1ns/10ps
`default_nettype none

module motor_rate_average (
	input  logic                                        us_clk,
	input  logic                                        machxo3_switch_reset_n,
	input  drone_values_pkg::motor_rates_t              rates,
	output logic [drone_values_pkg::MOTOR_RATE_WIDTH-1:0] avg_rate
);
	import drone_values_pkg::*;

	localparam int SUM_W = MOTOR_RATE_WIDTH + 2;	// Room for four full-scale rates

	logic [SUM_W-1:0] rate_sum;

	// Widen before adding so 4 x 255 still fits
	assign rate_sum = SUM_W'(rates.motor_1) + SUM_W'(rates.motor_2) +
			  SUM_W'(rates.motor_3) + SUM_W'(rates.motor_4);

	always_ff @(posedge us_clk or negedge machxo3_switch_reset_n) begin
		if (!machxo3_switch_reset_n)
			avg_rate <= '0;
		else
			avg_rate <= rate_sum[SUM_W-1:2];	// Divide by four, round down
	end

endmodule

`default_nettype wire

/* verilog/switch_decoder.sv */
// SWA/SWB decoder: maps the receiver switch channel to a registered switch position code
`timescale 1ns/10ps
`default_nettype none

module switch_decoder (
	input  logic                                     us_clk,
	input  logic                                     machxo3_switch_reset_n,
	input  logic                                     sys_rdy,
	input  logic [drone_values_pkg::REC_VAL_WIDTH-1:0] swa_swb_val,	// Combined switch channel
	output flight_modes_pkg::sw_pos_t                position
);
	import drone_values_pkg::*;
	import flight_modes_pkg::*;

	sw_pos_t pos_next;

	// Inclusive range test
	function automatic logic in_range(
		input logic [REC_VAL_WIDTH-1:0] val,
		input logic [REC_VAL_WIDTH-1:0] lo,
		input logic [REC_VAL_WIDTH-1:0] hi
	);
		return (val >= lo) && (val <= hi);
	endfunction

	// First matching range wins
	always_comb begin
		if (in_range(swa_swb_val, SW_OFF_MIN, SW_OFF_MAX))
			pos_next = SW_OFF;
		else if (in_range(swa_swb_val, SW_USER_IMU_MIN, SW_USER_IMU_MAX))
			pos_next = SW_USER_IMU;
		else if (in_range(swa_swb_val, SW_TAKE_OFF_IMU_MIN, SW_TAKE_OFF_IMU_MAX))
			pos_next = SW_TAKE_OFF_IMU;
		else if (in_range(swa_swb_val, SW_USER_NO_IMU_MIN, SW_USER_NO_IMU_MAX))
			pos_next = SW_USER_NO_IMU;
		else if (in_range(swa_swb_val, SW_TAKE_OFF_NO_IMU_MIN, SW_TAKE_OFF_NO_IMU_MAX))
			pos_next = SW_TAKE_OFF_NO_IMU;
		else
			pos_next = SW_OFF;	// Glitch or lost link, treat as off
	end

	// Switches are ignored until start-up is over
	always_ff @(posedge us_clk or negedge machxo3_switch_reset_n) begin
		if (!machxo3_switch_reset_n)
			position <= SW_OFF;
		else if (!sys_rdy)
			position <= SW_OFF;
		else
			position <= pos_next;
	end

	// Not ready on one edge means off on the next
	a_off_when_not_ready: assert property (
		@(posedge us_clk) disable iff (!machxo3_switch_reset_n)
		!$past(sys_rdy) |-> (position == SW_OFF)
	) else $error("position %h while system not ready", position);

endmodule

`default_nettype wire
